//--- Makefile
TOP = core_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f include/core_macros.svh $(wildcard source/*.sv) verification/core_tb.sv
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- include/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define CORE_XLEN        32
`define CORE_REG_COUNT   32
`define CORE_REG_ADDR_W  5

// ========================================
// RV32I opcodes handled by the core
// ========================================
`define CORE_OPC_OP      7'b0110011
`define CORE_OPC_OP_IMM  7'b0010011
`define CORE_OPC_LUI     7'b0110111

// Full ECALL word, no operand fields
`define CORE_ECALL       32'h00000073

`endif

//--- sim.f
+incdir+include
source/core_pkg.sv
source/reg_file.sv
source/alu.sv
source/instr_decode.sv
source/instr_execute.sv
source/result_writeback.sv
source/core_top.sv
verification/core_tb.sv

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::alu_op_e alu_op,
    input  core_pkg::word_t   operand_a,
    input  core_pkg::word_t   operand_b,
    output core_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = operand_b[4:0];
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            core_pkg::alu_add: begin
                result = operand_a + operand_b;
            end
            core_pkg::alu_sub: begin
                result = operand_a - operand_b;
            end
            core_pkg::alu_sll: begin
                result = operand_a << shamt;
            end
            // Compares give 1 or 0
            core_pkg::alu_slt: begin
                result = core_pkg::word_t'(lt_signed);
            end
            core_pkg::alu_sltu: begin
                result = core_pkg::word_t'(lt_unsigned);
            end
            core_pkg::alu_xor: begin
                result = operand_a ^ operand_b;
            end
            core_pkg::alu_srl: begin
                result = operand_a >> shamt;
            end
            core_pkg::alu_sra: begin
                result = core_pkg::word_t'($signed(operand_a) >>> shamt);
            end
            core_pkg::alu_or: begin
                result = operand_a | operand_b;
            end
            default: begin
                result = operand_a & operand_b;
            end
        endcase
    end

endmodule

//--- source/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

    // One data word and one register index
    typedef logic [`CORE_XLEN-1:0]       word_t;
    typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;

    // ========================================
    // ALU operations
    // ========================================
    // LUI runs as alu_add with a zero first operand
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

endpackage

//--- source/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                clock,
    input  logic                reset,
    // Instruction stream
    input  logic                instr_valid,
    input  core_pkg::word_t     instr_data,
    output logic                instr_ready,
    // Retire port, no back-pressure
    output logic                retire_valid,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_data
);

    logic                ex_valid;
    core_pkg::alu_op_e   ex_alu_op;
    core_pkg::reg_addr_t ex_rs1;
    core_pkg::reg_addr_t ex_rs2;
    core_pkg::reg_addr_t ex_rd;
    logic                ex_use_imm;
    logic                ex_zero_a;
    core_pkg::word_t     ex_imm;
    core_pkg::word_t     ex_rs1_data;
    core_pkg::word_t     ex_rs2_data;
    core_pkg::word_t     result_value;
    logic                wb_valid;
    core_pkg::reg_addr_t wb_rd;
    core_pkg::word_t     wb_data;

    // ========================================
    // Decode stage
    // ========================================
    instr_decode u_decode (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .ex_valid    (ex_valid),
        .ex_alu_op   (ex_alu_op),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_rd       (ex_rd),
        .ex_use_imm  (ex_use_imm),
        .ex_zero_a   (ex_zero_a),
        .ex_imm      (ex_imm),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    // ========================================
    // Execute stage
    // ========================================
    instr_execute u_execute (
        .ex_alu_op    (ex_alu_op),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_use_imm   (ex_use_imm),
        .ex_zero_a    (ex_zero_a),
        .ex_imm       (ex_imm),
        .ex_rs1_data  (ex_rs1_data),
        .ex_rs2_data  (ex_rs2_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .result_value (result_value)
    );

    // Valid and rd skip the ALU and go straight to the result stage
    result_writeback u_writeback (
        .clock        (clock),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .result_value (result_value),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    // The writeback record is also the retire record
    assign retire_valid = wb_valid;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

//--- source/instr_decode.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module instr_decode (
    input  logic                clock,
    input  logic                reset,
    // Instruction stream
    input  logic                instr_valid,
    input  core_pkg::word_t     instr_data,
    output logic                instr_ready,
    // Decode/execute register
    output logic                ex_valid,
    output core_pkg::alu_op_e   ex_alu_op,
    output core_pkg::reg_addr_t ex_rs1,
    output core_pkg::reg_addr_t ex_rs2,
    output core_pkg::reg_addr_t ex_rd,
    output logic                ex_use_imm,
    output logic                ex_zero_a,
    output core_pkg::word_t     ex_imm,
    output core_pkg::word_t     ex_rs1_data,
    output core_pkg::word_t     ex_rs2_data,
    // Writeback into the register file
    input  logic                wb_valid,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data
);

    logic                dec_valid;
    core_pkg::word_t     dec_instr;
    logic                halt;
    logic [6:0]          dec_opcode;
    logic [2:0]          dec_funct3;
    logic [6:0]          dec_funct7;
    core_pkg::reg_addr_t dec_rs1;
    core_pkg::reg_addr_t dec_rs2;
    core_pkg::reg_addr_t dec_rd;
    logic                is_op;
    logic                is_op_imm;
    logic                is_lui;
    logic                is_ecall;
    core_pkg::word_t     dec_imm;
    core_pkg::alu_op_e   dec_alu_op;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;

    // ========================================
    // Decode register and halt
    // ========================================
    // Nothing past an ECALL is taken in
    assign instr_ready = !halt && !(dec_valid && is_ecall);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
            halt      <= 1'b0;
        end else begin
            dec_valid <= instr_valid && instr_ready;
            if (dec_valid && is_ecall) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (instr_valid && instr_ready) begin
            dec_instr <= instr_data;
        end
    end

    // Instruction fields
    assign dec_opcode = dec_instr[6:0];
    assign dec_rd     = dec_instr[11:7];
    assign dec_funct3 = dec_instr[14:12];
    assign dec_rs1    = dec_instr[19:15];
    assign dec_rs2    = dec_instr[24:20];
    assign dec_funct7 = dec_instr[31:25];

    assign is_op     = (dec_opcode == `CORE_OPC_OP);
    assign is_op_imm = (dec_opcode == `CORE_OPC_OP_IMM);
    assign is_lui    = (dec_opcode == `CORE_OPC_LUI);
    assign is_ecall  = (dec_instr == `CORE_ECALL);

    // U-type for LUI, I-type otherwise
    assign dec_imm = is_lui ? {dec_instr[31:12], 12'b0}
                            : {{20{dec_instr[31]}}, dec_instr[31:20]};

    // ALU op select, funct7[5] is instruction bit 30
    always_comb begin
        dec_alu_op = core_pkg::alu_add;
        if (is_op || is_op_imm) begin
            case (dec_funct3)
                3'b000:  dec_alu_op = (is_op && dec_funct7[5]) ? core_pkg::alu_sub
                                                               : core_pkg::alu_add;
                3'b001:  dec_alu_op = core_pkg::alu_sll;
                3'b010:  dec_alu_op = core_pkg::alu_slt;
                3'b011:  dec_alu_op = core_pkg::alu_sltu;
                3'b100:  dec_alu_op = core_pkg::alu_xor;
                3'b101:  dec_alu_op = dec_funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                3'b110:  dec_alu_op = core_pkg::alu_or;
                default: dec_alu_op = core_pkg::alu_and;
            endcase
        end
    end

    reg_file u_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_valid (wb_valid),
        .wr_rd    (wb_rd),
        .wr_data  (wb_data)
    );

    // ========================================
    // Decode/execute register
    // ========================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid && (is_op || is_op_imm || is_lui);
        end
    end

    always_ff @(posedge clock) begin
        if (dec_valid) begin
            ex_alu_op   <= dec_alu_op;
            ex_rs1      <= dec_rs1;
            ex_rs2      <= dec_rs2;
            ex_rd       <= dec_rd;
            ex_use_imm  <= is_op_imm || is_lui;
            ex_zero_a   <= is_lui;
            ex_imm      <= dec_imm;
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
        end
    end

endmodule

//--- source/instr_execute.sv
`timescale 1ns/1ps

module instr_execute (
    // From the decode/execute register
    input  core_pkg::alu_op_e   ex_alu_op,
    input  core_pkg::reg_addr_t ex_rs1,
    input  core_pkg::reg_addr_t ex_rs2,
    input  logic                ex_use_imm,
    input  logic                ex_zero_a,
    input  core_pkg::word_t     ex_imm,
    input  core_pkg::word_t     ex_rs1_data,
    input  core_pkg::word_t     ex_rs2_data,
    // Result stage, for forwarding
    input  logic                wb_valid,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data,
    output core_pkg::word_t     result_value
);

    logic            fwd_a;
    logic            fwd_b;
    core_pkg::word_t src1_value;
    core_pkg::word_t src2_value;
    core_pkg::word_t operand_a;
    core_pkg::word_t operand_b;

    // ========================================
    // Forwarding from the result stage
    // ========================================
    // x0 is excluded so a discarded write to it never leaks through
    assign fwd_a = wb_valid && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign fwd_b = wb_valid && (wb_rd != '0) && (wb_rd == ex_rs2);

    // Older results already came in through the register file bypass
    assign src1_value = fwd_a ? wb_data : ex_rs1_data;
    assign src2_value = fwd_b ? wb_data : ex_rs2_data;

    // ========================================
    // Operand select
    // ========================================
    // Zero for LUI
    assign operand_a = ex_zero_a ? '0 : src1_value;

    // Immediate for OP-IMM and LUI
    assign operand_b = ex_use_imm ? ex_imm : src2_value;

    alu u_alu (
        .alu_op    (ex_alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (result_value)
    );

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module reg_file (
    input  logic               clock,
    input  logic               reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic               wr_valid,
    input  core_pkg::reg_addr_t wr_rd,
    input  core_pkg::word_t     wr_data
);

    core_pkg::word_t regs [`CORE_REG_COUNT];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid && (wr_rd != '0)) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // Read ports with write-through bypass
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else if (wr_valid && (wr_rd == rs1)) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
        end else if (wr_valid && (wr_rd == rs2)) begin
            rs2_data = wr_data;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

//--- source/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
    input  logic                clock,
    input  logic                reset,
    input  logic                ex_valid,
    input  core_pkg::reg_addr_t ex_rd,
    input  core_pkg::word_t     result_value,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);

    // ========================================
    // Execute/result register
    // ========================================
    // One record per retiring instruction, high for a single cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    // Payload only moves for a real instruction
    always_ff @(posedge clock) begin
        if (ex_valid) begin
            wb_rd   <= ex_rd;
            wb_data <= result_value;
        end
    end

endmodule

//--- verification/core_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module core_tb;

    localparam int READY_TIMEOUT  = 50;
    localparam int RETIRE_TIMEOUT = 50;
    localparam int HALT_WINDOW    = 20;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr_data;
    logic        instr_ready;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    // Program table with the expected retire of each entry
    logic [31:0] tbl_instr   [32];
    logic        tbl_retires [32];
    logic [4:0]  tbl_rd      [32];
    logic [31:0] tbl_value   [32];
    int          n_entries;
    int          n_retire;

    // Accepted retiring entries in arrival order
    int          pend_idx  [$];
    int          pend_edge [$];
    int          edge_count;
    int          retire_count;
    int          mon_idx;
    int          mon_edge;
    logic [31:0] lcg_state;
    int          gap;
    int          waited;

    core_top DUT (
        .clock        (clock),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .instr_ready  (instr_ready),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        edge_count <= edge_count + 1;
    end

    // ========================================
    // Reporting and encoding helpers
    // ========================================
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at %0t ns: %s expected 0x%08h, actual 0x%08h",
                 $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopped on an error");
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, `CORE_OPC_OP_IMM};
    endfunction

    // Also used for the immediate shifts with the shift amount in the rs2 field
    function automatic logic [31:0] r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] funct3,
                                                input logic [4:0] rd, input logic [6:0] opcode);
        return {funct7, rs2, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `CORE_OPC_LUI};
    endfunction

    task automatic add_entry(input logic [31:0] word, input logic retires,
                             input logic [4:0] rd, input logic [31:0] value);
        tbl_instr[n_entries]   = word;
        tbl_retires[n_entries] = retires;
        tbl_rd[n_entries]      = rd;
        tbl_value[n_entries]   = value;
        n_entries++;
        if (retires) begin
            n_retire++;
        end
    endtask

    // Holds the word until the core takes it and notes the accept edge
    task automatic send_instr(input int idx);
        int wait_cycles;
        wait_cycles = 0;
        instr_valid = 1'b1;
        instr_data  = tbl_instr[idx];
        while (!instr_ready) begin
            @(negedge clock);
            wait_cycles++;
            if (wait_cycles > READY_TIMEOUT) begin
                report_failure("instr_ready stayed low while an instruction was waiting");
            end
        end
        if (tbl_retires[idx]) begin
            pend_idx.push_back(idx);
            pend_edge.push_back(edge_count + 1);
        end
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    task automatic fill_table;
        // Register-immediate and LUI
        add_entry(i_type_word(12'hFFB, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'hFFFF_FFFB);
        add_entry(i_type_word(12'hFFD, 5'd1, 3'b010, 5'd2), 1'b1, 5'd2, 32'h0000_0001);
        add_entry(i_type_word(12'h005, 5'd1, 3'b011, 5'd3), 1'b1, 5'd3, 32'h0000_0000);
        add_entry(i_type_word(12'h0F0, 5'd1, 3'b100, 5'd4), 1'b1, 5'd4, 32'hFFFF_FF0B);
        add_entry(i_type_word(12'h123, 5'd0, 3'b110, 5'd5), 1'b1, 5'd5, 32'h0000_0123);
        add_entry(i_type_word(12'h7FF, 5'd4, 3'b111, 5'd6), 1'b1, 5'd6, 32'h0000_070B);
        add_entry(r_type_word(7'h00, 5'd4, 5'd5, 3'b001, 5'd7, `CORE_OPC_OP_IMM),
                  1'b1, 5'd7, 32'h0000_1230);
        add_entry(r_type_word(7'h00, 5'd28, 5'd1, 3'b101, 5'd8, `CORE_OPC_OP_IMM),
                  1'b1, 5'd8, 32'h0000_000F);
        add_entry(r_type_word(7'h20, 5'd1, 5'd1, 3'b101, 5'd9, `CORE_OPC_OP_IMM),
                  1'b1, 5'd9, 32'hFFFF_FFFD);
        add_entry(lui_word(20'h12345, 5'd10), 1'b1, 5'd10, 32'h1234_5000);
        // Register-register with producers right before or two before consumers
        add_entry(r_type_word(7'h00, 5'd5, 5'd10, 3'b000, 5'd11, `CORE_OPC_OP),
                  1'b1, 5'd11, 32'h1234_5123);
        add_entry(r_type_word(7'h20, 5'd7, 5'd11, 3'b000, 5'd12, `CORE_OPC_OP),
                  1'b1, 5'd12, 32'h1234_3EF3);
        add_entry(r_type_word(7'h00, 5'd8, 5'd5, 3'b001, 5'd13, `CORE_OPC_OP),
                  1'b1, 5'd13, 32'h0091_8000);
        add_entry(r_type_word(7'h00, 5'd12, 5'd1, 3'b010, 5'd14, `CORE_OPC_OP),
                  1'b1, 5'd14, 32'h0000_0001);
        add_entry(r_type_word(7'h00, 5'd12, 5'd1, 3'b011, 5'd15, `CORE_OPC_OP),
                  1'b1, 5'd15, 32'h0000_0000);
        add_entry(r_type_word(7'h00, 5'd9, 5'd14, 3'b100, 5'd16, `CORE_OPC_OP),
                  1'b1, 5'd16, 32'hFFFF_FFFC);
        add_entry(r_type_word(7'h00, 5'd8, 5'd16, 3'b101, 5'd17, `CORE_OPC_OP),
                  1'b1, 5'd17, 32'h0001_FFFF);
        add_entry(r_type_word(7'h20, 5'd8, 5'd16, 3'b101, 5'd18, `CORE_OPC_OP),
                  1'b1, 5'd18, 32'hFFFF_FFFF);
        add_entry(r_type_word(7'h00, 5'd13, 5'd17, 3'b110, 5'd19, `CORE_OPC_OP),
                  1'b1, 5'd19, 32'h0091_FFFF);
        add_entry(r_type_word(7'h00, 5'd4, 5'd19, 3'b111, 5'd20, `CORE_OPC_OP),
                  1'b1, 5'd20, 32'h0091_FF0B);
        // x0 retires its value but keeps reading as zero
        add_entry(i_type_word(12'h005, 5'd20, 3'b000, 5'd0), 1'b1, 5'd0, 32'h0091_FF10);
        add_entry(r_type_word(7'h00, 5'd5, 5'd0, 3'b000, 5'd21, `CORE_OPC_OP),
                  1'b1, 5'd21, 32'h0000_0123);
        add_entry(r_type_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd22, `CORE_OPC_OP),
                  1'b1, 5'd22, 32'h0000_0000);
        add_entry(r_type_word(7'h20, 5'd5, 5'd0, 3'b000, 5'd23, `CORE_OPC_OP),
                  1'b1, 5'd23, 32'hFFFF_FEDD);
        add_entry(`CORE_ECALL, 1'b0, 5'd0, 32'h0000_0000);
    endtask

    // ========================================
    // Retire monitor
    // ========================================
    // Results come in table order two edges after their accept edge
    always @(negedge clock) begin
        if (!reset && retire_valid) begin
            assert (pend_idx.size() > 0)
                else report_failure("a result retired with no accepted instruction pending");
            mon_idx  = pend_idx.pop_front();
            mon_edge = pend_edge.pop_front();
            assert (retire_rd == tbl_rd[mon_idx])
                else report_mismatch("retire_rd", 32'(tbl_rd[mon_idx]), 32'(retire_rd));
            assert (retire_data == tbl_value[mon_idx])
                else report_mismatch("retire_data", tbl_value[mon_idx], retire_data);
            assert (edge_count == mon_edge + 2)
                else report_mismatch("retire edge", 32'(mon_edge + 2), 32'(edge_count));
            retire_count++;
        end
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr_data   = 32'h0;
        edge_count   = 0;
        retire_count = 0;
        n_entries    = 0;
        n_retire     = 0;
        lcg_state    = 32'h2f84;
        fill_table();

        repeat (8) begin
            @(negedge clock);
            assert (retire_valid == 1'b0)
                else report_mismatch("retire_valid", 32'h0, 32'(retire_valid));
        end
        reset = 1'b0;
        @(negedge clock);
        assert (retire_valid == 1'b0)
            else report_mismatch("retire_valid", 32'h0, 32'(retire_valid));
        assert (instr_ready == 1'b1)
            else report_mismatch("instr_ready", 32'h1, 32'(instr_ready));

        // Random idle gap of 0 to 3 cycles before every entry
        for (int i = 0; i < n_entries; i++) begin
            lcg_state = next_random(lcg_state);
            gap       = int'(lcg_state[31:30]);
            repeat (gap) @(negedge clock);
            send_instr(i);
        end

        // An instruction offered after the ECALL must never be taken
        instr_valid = 1'b1;
        instr_data  = i_type_word(12'h001, 5'd0, 3'b000, 5'd24);
        waited      = 0;
        while (instr_ready) begin
            if (waited >= 2) begin
                report_failure("instr_ready stayed high after the ECALL was accepted");
            end
            @(negedge clock);
            waited++;
        end
        repeat (HALT_WINDOW) begin
            @(negedge clock);
            assert (instr_ready == 1'b0)
                else report_mismatch("instr_ready", 32'h0, 32'(instr_ready));
        end

        waited = 0;
        while (retire_count < n_retire) begin
            @(negedge clock);
            waited++;
            if (waited > RETIRE_TIMEOUT) begin
                report_failure("not every instruction in the table retired");
            end
        end
        instr_valid = 1'b0;

        $display("TEST PASSED");
        $finish;
    end

endmodule
